//--- hw/jtag_loader_pkg.sv
package jtag_loader_pkg;

	// instruction memory geometry.
	parameter int addr_width = 10;
	parameter int instr_width = 18;

	// bank count when the top level is not overridden.
	parameter int default_num_banks = 2;

	// one processor instruction.
	typedef logic [instr_width-1:0] instr_t;

	// one program memory address.
	typedef logic [addr_width-1:0] addr_t;

	// frame fields other than the bank select mask.
	// the mask width follows num_banks, so it travels beside this struct.
	typedef struct packed {
		// 1 commits the mask into the processor reset register.
		logic   ctrl;
		// 1 writes data into every selected bank.
		logic   we;
		// write address, also the readback address.
		addr_t  addr;
		// instruction word to store.
		instr_t data;
	} loader_frame_t;

	// shared write bus, one per loader, fanned out to all banks.
	// each bank qualifies it with its own enable bit.
	typedef struct packed {
		addr_t  addr;
		instr_t data;
	} bram_wr_t;

endpackage

//--- hw/jtag_shifter.sv
`timescale 1ns/1ps

module jtag_shifter import jtag_loader_pkg::*; #(
	parameter int num_banks = default_num_banks
) (
	input  logic                 shift_clk,
	input  logic                 shift,
	input  logic                 shift_din,
	input  logic                 capture,
	input  instr_t               readback,
	output loader_frame_t        frame,
	output logic [num_banks-1:0] sel,
	output logic                 shift_dout
);

	// chain layout, bit 0 nearest shift_din.
	// ctrl, sel[0..n-1], we, addr[0..], data[0..].
	localparam int ctrl_bit  = 0;
	localparam int sel_lsb   = ctrl_bit + 1;
	localparam int we_bit    = sel_lsb + num_banks;
	localparam int addr_lsb  = we_bit + 1;
	localparam int data_lsb  = addr_lsb + addr_width;
	localparam int chain_len = data_lsb + instr_width;

	// the whole frame as one shift register.
	logic [chain_len-1:0] chain;

	// every bit moves one place inward per shift edge.
	// capture replaces the data field so it can be clocked out.
	always_ff @(posedge shift_clk) begin
		if (capture) begin
			chain[data_lsb +: instr_width] <= readback;
		end else if (shift) begin
			chain <= {chain[chain_len-2:0], shift_din};
		end
	end

	// parallel view of the frame for the update logic.
	assign frame = '{
		ctrl: chain[ctrl_bit],
		we:   chain[we_bit],
		addr: chain[addr_lsb +: addr_width],
		data: chain[data_lsb +: instr_width]
	};

	assign sel = chain[sel_lsb +: num_banks];

	// data msb leaves first.
	assign shift_dout = chain[chain_len-1];

endmodule

//--- hw/loader_update.sv
`timescale 1ns/1ps

module loader_update import jtag_loader_pkg::*; #(
	parameter int num_banks = default_num_banks
) (
	input  logic                 shift_clk,
	input  logic                 rst,
	input  logic                 update,
	input  loader_frame_t        frame,
	input  logic [num_banks-1:0] sel,
	output bram_wr_t             wr,
	output logic [num_banks-1:0] wr_en,
	output addr_t                rd_addr,
	output logic [num_banks-1:0] rd_sel,
	output logic [num_banks-1:0] proc_reset
);

	// frame decode, only here.
	logic commit_ctrl;
	logic commit_write;

	assign commit_ctrl  = update && frame.ctrl;
	assign commit_write = update && !frame.ctrl && frame.we;

	// enables last one cycle.
	// the banks see the write on the edge after the update.
	always_ff @(posedge shift_clk) begin
		if (rst) begin
			wr_en <= '0;
		end else if (commit_write) begin
			wr_en <= sel;
		end else begin
			wr_en <= '0;
		end
	end

	// write payload follows every update.
	always_ff @(posedge shift_clk) begin
		if (update) begin
			wr.addr <= frame.addr;
			wr.data <= frame.data;
		end
	end

	// readback target moves on every update, whatever the frame kind.
	always_ff @(posedge shift_clk) begin
		if (rst) begin
			rd_addr <= '0;
			rd_sel  <= '0;
		end else if (update) begin
			rd_addr <= frame.addr;
			rd_sel  <= sel;
		end
	end

	// per-processor reset, held until the next control frame.
	always_ff @(posedge shift_clk) begin
		if (rst) begin
			proc_reset <= '0;
		end else if (commit_ctrl) begin
			proc_reset <= sel;
		end
	end

endmodule

//--- hw/program_ram.sv
`timescale 1ns/1ps

module program_ram import jtag_loader_pkg::*; (
	input  logic     shift_clk,
	input  logic     wr_en,
	input  bram_wr_t wr,
	input  addr_t    rd_addr,
	output instr_t   rd_data,
	input  addr_t    fetch_addr,
	output instr_t   fetch_instr
);

	localparam int depth = 2 ** addr_width;

	// one program image.
	instr_t mem [depth];

	// loader port, write plus read.
	// the read returns the old word when both hit the same address.
	always_ff @(posedge shift_clk) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.data;
		end
		rd_data <= mem[rd_addr];
	end

	// processor fetch port.
	always_ff @(posedge shift_clk) begin
		fetch_instr <= mem[fetch_addr];
	end

endmodule

//--- hw/readback_mux.sv
`timescale 1ns/1ps

module readback_mux import jtag_loader_pkg::*; #(
	parameter int num_banks = default_num_banks
) (
	input  logic                 shift_clk,
	input  logic                 rst,
	input  logic [num_banks-1:0] rd_sel,
	input  instr_t               rd_data [num_banks],
	output instr_t               readback
);

	instr_t pick;

	// lowest selected bank wins.
	// walk down from the top so the last hit is the lowest index.
	always_comb begin
		pick = '0;
		for (int i = num_banks - 1; i >= 0; i--) begin
			if (rd_sel[i]) begin
				pick = rd_data[i];
			end
		end
	end

	// registered ahead of the shifter capture.
	always_ff @(posedge shift_clk) begin
		if (rst) begin
			readback <= '0;
		end else begin
			readback <= pick;
		end
	end

endmodule

//--- hw/jtag_loader.sv
`timescale 1ns/1ps

module jtag_loader import jtag_loader_pkg::*; #(
	parameter int num_banks = default_num_banks
) (
	input  logic                 shift_clk,
	input  logic                 rst,
	input  logic                 shift,
	input  logic                 shift_din,
	input  logic                 update,
	input  logic                 capture,
	output logic                 shift_dout,
	output logic [num_banks-1:0] proc_reset,
	input  addr_t                fetch_addr [num_banks],
	output instr_t               fetch_instr [num_banks]
);

	loader_frame_t        frame;
	logic [num_banks-1:0] sel;
	bram_wr_t             wr;
	logic [num_banks-1:0] wr_en;
	addr_t                rd_addr;
	logic [num_banks-1:0] rd_sel;
	instr_t               rd_data [num_banks];
	instr_t               readback;

	jtag_shifter #(
		.num_banks (num_banks)
	) i_shifter (
		.shift_clk  (shift_clk),
		.shift      (shift),
		.shift_din  (shift_din),
		.capture    (capture),
		.readback   (readback),
		.frame      (frame),
		.sel        (sel),
		.shift_dout (shift_dout)
	);

	loader_update #(
		.num_banks (num_banks)
	) i_update (
		.shift_clk  (shift_clk),
		.rst        (rst),
		.update     (update),
		.frame      (frame),
		.sel        (sel),
		.wr         (wr),
		.wr_en      (wr_en),
		.rd_addr    (rd_addr),
		.rd_sel     (rd_sel),
		.proc_reset (proc_reset)
	);

	// one memory per processor, all on the same write bus.
	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		program_ram i_ram (
			.shift_clk   (shift_clk),
			.wr_en       (wr_en[b]),
			.wr          (wr),
			.rd_addr     (rd_addr),
			.rd_data     (rd_data[b]),
			.fetch_addr  (fetch_addr[b]),
			.fetch_instr (fetch_instr[b])
		);
	end

	readback_mux #(
		.num_banks (num_banks)
	) i_readback (
		.shift_clk (shift_clk),
		.rst       (rst),
		.rd_sel    (rd_sel),
		.rd_data   (rd_data),
		.readback  (readback)
	);

endmodule

//--- testbench/jtag_loader_props.sv
`timescale 1ns/1ps

module jtag_loader_props import jtag_loader_pkg::*; #(
	parameter int num_banks = default_num_banks
) (
	input logic                 shift_clk,
	input logic                 rst,
	input logic                 update,
	input logic                 capture,
	input logic                 shift,
	input logic [num_banks-1:0] wr_en,
	input logic [num_banks-1:0] proc_reset
);

	int fail_count = 0;

	// enables are the registered copy of a write commit.
	a_wr_en_after_update: assert property (
		@(posedge shift_clk) disable iff (rst) (wr_en != '0) |-> $past(update)
	) else begin
		$error("wr_en set without an update on the previous edge");
		fail_count++;
	end

	a_proc_reset_hold: assert property (
		@(posedge shift_clk) disable iff (rst) !$past(update) |-> $stable(proc_reset)
	) else begin
		$error("proc_reset changed without an update");
		fail_count++;
	end

	a_pulses_exclusive: assert property (
		@(posedge shift_clk) $onehot0({update, capture, shift})
	) else begin
		$error("update, capture and shift overlap");
		fail_count++;
	end

endmodule

bind jtag_loader jtag_loader_props #(
	.num_banks (num_banks)
) i_props (
	.shift_clk  (shift_clk),
	.rst        (rst),
	.update     (update),
	.capture    (capture),
	.shift      (shift),
	.wr_en      (wr_en),
	.proc_reset (proc_reset)
);

//--- testbench/tb_jtag_loader.sv
`timescale 1ns/1ps

module tb_jtag_loader import jtag_loader_pkg::*; ();

	localparam int num_banks = 2;
	localparam int frame_len = 2 + num_banks + addr_width + instr_width;
	// update to capture, covers write, bank read and readback register.
	localparam int settle_cycles = 6;

	typedef enum logic [1:0] {
		k_write,
		k_read,
		k_ctrl,
		k_fetch
	} kind_t;

	typedef struct packed {
		kind_t                kind;
		logic [num_banks-1:0] sel;
		addr_t                addr;
		instr_t               data;
		instr_t               expected;
	} entry_t;

	logic                 shift_clk = 1'b0;
	logic                 rst;
	logic                 shift;
	logic                 shift_din;
	logic                 update;
	logic                 capture;
	logic                 shift_dout;
	logic [num_banks-1:0] proc_reset;
	addr_t                fetch_addr [num_banks];
	instr_t               fetch_instr [num_banks];

	entry_t               tests [$];
	logic                 tests_ready = 1'b0;
	integer               seed = 32'had4d;

	// reference model of the banks and the reset register.
	instr_t               model_mem [num_banks][2 ** addr_width];
	logic [num_banks-1:0] model_reset = '0;

	jtag_loader #(
		.num_banks (num_banks)
	) i_jtag_loader (
		.shift_clk   (shift_clk),
		.rst         (rst),
		.shift       (shift),
		.shift_din   (shift_din),
		.update      (update),
		.capture     (capture),
		.shift_dout  (shift_dout),
		.proc_reset  (proc_reset),
		.fetch_addr  (fetch_addr),
		.fetch_instr (fetch_instr)
	);

	always #5 shift_clk = ~shift_clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic int lowest_bank(input logic [num_banks-1:0] sel);
		int idx;
		idx = 0;
		for (int b = num_banks - 1; b >= 0; b--) begin
			if (sel[b]) begin
				idx = b;
			end
		end
		return idx;
	endfunction

	// computes the expected value and moves the model on.
	task automatic add_entry(input kind_t kind, input logic [num_banks-1:0] sel,
			input addr_t addr, input instr_t data);
		entry_t e;
		e.kind = kind;
		e.sel = sel;
		e.addr = addr;
		e.data = data;
		e.expected = '0;
		case (kind)
			k_write: begin
				for (int b = 0; b < num_banks; b++) begin
					if (sel[b]) begin
						model_mem[b][addr] = data;
					end
				end
				e.expected = instr_t'(model_reset);
			end
			k_ctrl: begin
				model_reset = sel;
				e.expected = instr_t'(sel);
			end
			default: begin
				// readback and fetch both look at the lowest selected bank.
				if (sel != '0) begin
					e.expected = model_mem[lowest_bank(sel)][addr];
				end
			end
		endcase
		tests.push_back(e);
	endtask

	task automatic build_table();
		addr_t                a0;
		addr_t                a1;
		addr_t                ra;
		instr_t               d [4];
		instr_t               rd;
		logic [num_banks-1:0] mask;
		a0 = $random(seed);
		a1 = ~a0;
		for (int i = 0; i < 4; i++) begin
			d[i] = $random(seed);
		end
		add_entry(k_read, 2'b00, a0, d[3]);
		add_entry(k_write, 2'b01, a0, d[0]);
		add_entry(k_read, 2'b01, a0, d[3]);
		// both banks take the same word.
		add_entry(k_write, 2'b11, a1, d[1]);
		add_entry(k_fetch, 2'b01, a1, '0);
		add_entry(k_fetch, 2'b10, a1, '0);
		add_entry(k_read, 2'b10, a1, '0);
		// bank 1 only, bank 0 keeps d[1].
		add_entry(k_write, 2'b10, a1, d[2]);
		add_entry(k_fetch, 2'b01, a1, '0);
		add_entry(k_fetch, 2'b10, a1, '0);
		// banks now differ here, so the lower one must win.
		add_entry(k_read, 2'b11, a1, '0);
		// control frames carry the write flag too, and still write nothing.
		add_entry(k_ctrl, 2'b10, a1, d[3]);
		add_entry(k_fetch, 2'b10, a1, '0);
		add_entry(k_fetch, 2'b01, a1, '0);
		add_entry(k_ctrl, 2'b00, a1, d[3]);
		// read frame with stray data, memory must keep d[0].
		add_entry(k_read, 2'b01, a0, d[3]);
		add_entry(k_fetch, 2'b01, a0, '0);
		for (int i = 0; i < 4; i++) begin
			mask = $random(seed);
			if (mask == '0) begin
				mask = 2'b01;
			end
			ra = $random(seed);
			rd = $random(seed);
			add_entry(k_write, mask, ra, rd);
			add_entry(k_read, mask, ra, '0);
		end
	endtask

	task automatic settle();
		repeat (settle_cycles) @(negedge shift_clk);
	endtask

	// data msb first, ctrl last, then one update cycle.
	task automatic send_frame(input logic ctrl, input logic we,
			input logic [num_banks-1:0] sel, input addr_t addr, input instr_t data);
		logic [frame_len-1:0] bits;
		bits = {data, addr, we, sel, ctrl};
		for (int i = frame_len - 1; i >= 0; i--) begin
			shift = 1'b1;
			shift_din = bits[i];
			@(negedge shift_clk);
		end
		shift = 1'b0;
		shift_din = 1'b0;
		update = 1'b1;
		@(negedge shift_clk);
		update = 1'b0;
	endtask

	task automatic read_back(output instr_t word);
		capture = 1'b1;
		@(negedge shift_clk);
		capture = 1'b0;
		for (int i = instr_width - 1; i >= 0; i--) begin
			word[i] = shift_dout;
			shift = 1'b1;
			@(negedge shift_clk);
		end
		shift = 1'b0;
	endtask

	task automatic fetch_word(input int bank, input addr_t addr, output instr_t word);
		fetch_addr[bank] = addr;
		@(negedge shift_clk);
		word = fetch_instr[bank];
	endtask

	task automatic run_entry(input entry_t e);
		instr_t got;
		int     bank;
		case (e.kind)
			k_write: begin
				send_frame(1'b0, 1'b1, e.sel, e.addr, e.data);
				settle();
				check_value("proc_reset", proc_reset, e.expected);
			end
			k_ctrl: begin
				send_frame(1'b1, 1'b1, e.sel, e.addr, e.data);
				settle();
				check_value("proc_reset", proc_reset, e.expected);
			end
			k_read: begin
				send_frame(1'b0, 1'b0, e.sel, e.addr, e.data);
				settle();
				read_back(got);
				check_value("shift_dout", got, e.expected);
			end
			default: begin
				bank = lowest_bank(e.sel);
				fetch_word(bank, e.addr, got);
				check_value($sformatf("fetch_instr[%0d]", bank), got, e.expected);
			end
		endcase
	endtask

	initial begin
		instr_t word;
		rst = 1'b1;
		shift = 1'b0;
		shift_din = 1'b0;
		update = 1'b0;
		capture = 1'b0;
		for (int b = 0; b < num_banks; b++) begin
			fetch_addr[b] = '0;
		end
		build_table();
		tests_ready = 1'b1;
		repeat (10) @(negedge shift_clk);
		rst = 1'b0;
		@(negedge shift_clk);
		check_value("proc_reset", proc_reset, '0);
		read_back(word);
		check_value("shift_dout", word, '0);
		foreach (tests[i]) begin
			run_entry(tests[i]);
		end
		if (i_jtag_loader.i_props.fail_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Simulation FAILED");
			$fatal(1, "assertion failures in the bound properties");
		end
	end

	// a bound assertion failure ends the run at once.
	initial begin
		wait (i_jtag_loader.i_props.fail_count != 0);
		$display("Simulation FAILED");
		$fatal(1, "a bound assertion failed");
	end

	// watchdog, sized from the table once it is built.
	initial begin
		wait (tests_ready);
		repeat (tests.size() * frame_len * 3) @(posedge shift_clk);
		$display("timeout, the test table did not finish in %0d cycles",
			tests.size() * frame_len * 3);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- tb.f
hw/jtag_loader_pkg.sv
hw/jtag_shifter.sv
hw/loader_update.sv
hw/program_ram.sv
hw/readback_mux.sv
hw/jtag_loader.sv
testbench/jtag_loader_props.sv
testbench/tb_jtag_loader.sv

//--- Bender.yml
package:
  name: jtag_loader

sources:
  # design, package first
  - files:
      - hw/jtag_loader_pkg.sv
      - hw/jtag_shifter.sv
      - hw/loader_update.sv
      - hw/program_ram.sv
      - hw/readback_mux.sv
      - hw/jtag_loader.sv

  # testbench and bound properties
  - target: test
    files:
      - testbench/jtag_loader_props.sv
      - testbench/tb_jtag_loader.sv
